// File: legv8_pipeline.f
+incdir+include
rtl/legv8_isa_pkg.sv
rtl/legv8_datapath_pkg.sv
rtl/fetch_decode.sv
rtl/register_file.sv
rtl/execute_memory.sv
rtl/legv8_core.sv
verif/clock_gen.sv
verif/tb_legv8.sv

// File: rtl/execute_memory.sv
`timescale 1ns/100ps

module execute_memory (
  input  logic                                          CLOCK,
  input  logic                                          rst,
  input  legv8_isa_pkg::instr_kind_t                    kind,
  input  legv8_datapath_pkg::alu_op_t                   alu_op,
  input  logic [legv8_datapath_pkg::reg_addr_width-1:0] rd,
  input  logic [legv8_datapath_pkg::xlen-1:0]           imm,
  input  logic [legv8_datapath_pkg::xlen-1:0]           rs1_data,
  input  logic [legv8_datapath_pkg::xlen-1:0]           rs2_data,
  input  logic [legv8_datapath_pkg::xlen-1:0]           mem_rdata,
  output logic [legv8_datapath_pkg::xlen-1:0]           mem_addr,
  output logic [legv8_datapath_pkg::xlen-1:0]           mem_wdata,
  output logic                                          mem_read,
  output logic                                          mem_write,
  output logic                                          wb_en,
  output logic [legv8_datapath_pkg::reg_addr_width-1:0] wb_addr,
  output logic [legv8_datapath_pkg::xlen-1:0]           wb_data
);

  localparam int xlen = legv8_datapath_pkg::xlen;
  localparam int aw   = legv8_datapath_pkg::reg_addr_width;

  legv8_isa_pkg::instr_kind_t  dx_kind;  // ID/EX
  legv8_datapath_pkg::alu_op_t dx_alu_op;
  logic [aw-1:0]               dx_rd;
  logic [xlen-1:0]             dx_imm;
  logic [xlen-1:0]             dx_rs1;
  logic [xlen-1:0]             dx_rs2;

  logic [xlen-1:0]             alu_b;
  logic [xlen-1:0]             alu_result;

  legv8_isa_pkg::instr_kind_t  xm_kind;  // EX/MEM
  logic [aw-1:0]               xm_rd;
  logic [xlen-1:0]             xm_result;
  logic [xlen-1:0]             xm_store_data;

  logic                        mw_wb_en;  // MEM/WB
  logic                        mw_is_load;
  logic [aw-1:0]               mw_rd;
  logic [xlen-1:0]             mw_rdata;
  logic [xlen-1:0]             mw_result;

  always_ff @(posedge CLOCK) begin
    if (rst) begin
      dx_kind  <= legv8_isa_pkg::kind_bubble;
      xm_kind  <= legv8_isa_pkg::kind_bubble;
      mw_wb_en <= 1'b0;
    end else begin
      dx_kind  <= kind;
      xm_kind  <= dx_kind;
      mw_wb_en <= (xm_kind == legv8_isa_pkg::kind_alu) ||
                  (xm_kind == legv8_isa_pkg::kind_load);
    end
  end

  always_ff @(posedge CLOCK) begin
    dx_alu_op     <= alu_op;
    dx_rd         <= rd;
    dx_imm        <= imm;
    dx_rs1        <= rs1_data;
    dx_rs2        <= rs2_data;
    xm_rd         <= dx_rd;
    xm_result     <= alu_result;
    xm_store_data <= dx_rs2;  // Rt value for STUR
    mw_is_load    <= (xm_kind == legv8_isa_pkg::kind_load);
    mw_rd         <= xm_rd;
    mw_rdata      <= mem_rdata;
    mw_result     <= xm_result;
  end

  // Second operand is the offset for D-type
  assign alu_b = ((dx_kind == legv8_isa_pkg::kind_load) ||
                  (dx_kind == legv8_isa_pkg::kind_store)) ? dx_imm : dx_rs2;

  always_comb begin
    case (dx_alu_op)
      legv8_datapath_pkg::alu_and: alu_result = dx_rs1 & alu_b;
      legv8_datapath_pkg::alu_orr: alu_result = dx_rs1 | alu_b;
      legv8_datapath_pkg::alu_add: alu_result = dx_rs1 + alu_b;
      legv8_datapath_pkg::alu_sub: alu_result = dx_rs1 - alu_b;
      default:                     alu_result = '0;
    endcase
  end

  assign mem_addr  = xm_result;
  assign mem_wdata = xm_store_data;
  assign mem_read  = (xm_kind == legv8_isa_pkg::kind_load);
  assign mem_write = (xm_kind == legv8_isa_pkg::kind_store);

  assign wb_en   = mw_wb_en;
  assign wb_addr = mw_rd;
  assign wb_data = mw_is_load ? mw_rdata : mw_result;  // Load data or ALU result

  a_rw_exclusive: assert property (@(posedge CLOCK) disable iff (rst)
    !(mem_read && mem_write))
    else $error("mem_read and mem_write both high");

endmodule

// File: rtl/fetch_decode.sv
`timescale 1ns/100ps

module fetch_decode #(
  parameter logic [legv8_datapath_pkg::xlen-1:0] reset_pc = '0
) (
  input  logic                                          CLOCK,
  input  logic                                          rst,
  input  logic [legv8_isa_pkg::instr_width-1:0]         instr,
  output logic [legv8_datapath_pkg::xlen-1:0]           pc,
  output logic [legv8_datapath_pkg::reg_addr_width-1:0] rs1_addr,
  output logic [legv8_datapath_pkg::reg_addr_width-1:0] rs2_addr,
  output legv8_isa_pkg::instr_kind_t                    kind,
  output legv8_datapath_pkg::alu_op_t                   alu_op,
  output logic [legv8_datapath_pkg::reg_addr_width-1:0] rd,
  output logic [legv8_datapath_pkg::xlen-1:0]           imm
);

  localparam int aw = legv8_datapath_pkg::reg_addr_width;
  localparam int iw = legv8_isa_pkg::dt_imm_width;

  logic [legv8_isa_pkg::instr_width-1:0] fetch_ir;  // IF/ID instruction word
  legv8_isa_pkg::opcode_t                opcode;
  logic [aw-1:0]                         rm_field;
  logic [aw-1:0]                         rt_field;
  logic [iw-1:0]                         dt_imm;

  always_ff @(posedge CLOCK) begin
    if (rst) begin
      pc       <= reset_pc;
      fetch_ir <= '0;  // Opcode 0 decodes as a bubble
    end else begin
      pc       <= pc + legv8_datapath_pkg::pc_step;
      fetch_ir <= instr;
    end
  end

  assign opcode   = legv8_isa_pkg::opcode_t'(
                      fetch_ir[legv8_isa_pkg::opcode_lsb +: legv8_isa_pkg::opcode_width]);
  assign rm_field = fetch_ir[legv8_isa_pkg::rm_lsb +: aw];
  assign rt_field = fetch_ir[legv8_isa_pkg::rd_lsb +: aw];
  assign dt_imm   = fetch_ir[legv8_isa_pkg::dt_imm_lsb +: iw];

  always_comb begin
    alu_op = legv8_datapath_pkg::alu_add;  // Address add for loads and stores
    case (opcode)
      legv8_isa_pkg::op_add:  kind = legv8_isa_pkg::kind_alu;
      legv8_isa_pkg::op_sub: begin
        kind   = legv8_isa_pkg::kind_alu;
        alu_op = legv8_datapath_pkg::alu_sub;
      end
      legv8_isa_pkg::op_and: begin
        kind   = legv8_isa_pkg::kind_alu;
        alu_op = legv8_datapath_pkg::alu_and;
      end
      legv8_isa_pkg::op_orr: begin
        kind   = legv8_isa_pkg::kind_alu;
        alu_op = legv8_datapath_pkg::alu_orr;
      end
      legv8_isa_pkg::op_ldur: kind = legv8_isa_pkg::kind_load;
      legv8_isa_pkg::op_stur: kind = legv8_isa_pkg::kind_store;
      default:                kind = legv8_isa_pkg::kind_bubble;  // Unknown opcode
    endcase
  end

  assign rs1_addr = fetch_ir[legv8_isa_pkg::rn_lsb +: aw];
  // Stores read Rt as the second operand, ALU forms read Rm
  assign rs2_addr = (kind == legv8_isa_pkg::kind_store) ? rt_field : rm_field;
  assign rd       = rt_field;
  assign imm      = {{(legv8_datapath_pkg::xlen - iw){dt_imm[iw-1]}}, dt_imm};

  a_pc_aligned: assert property (@(posedge CLOCK) disable iff (rst) pc[1:0] == 2'b00)
    else $error("pc lost word alignment: %h", pc);

endmodule

// File: rtl/legv8_core.sv
`timescale 1ns/100ps

module legv8_core #(
  parameter logic [legv8_datapath_pkg::xlen-1:0] reset_pc = '0
) (
  input  logic                                  CLOCK,
  input  logic                                  rst,
  input  logic [legv8_isa_pkg::instr_width-1:0] instr,
  input  logic [legv8_datapath_pkg::xlen-1:0]   mem_rdata,
  output logic [legv8_datapath_pkg::xlen-1:0]   pc,
  output logic [legv8_datapath_pkg::xlen-1:0]   mem_addr,
  output logic [legv8_datapath_pkg::xlen-1:0]   mem_wdata,
  output logic                                  mem_read,
  output logic                                  mem_write
);

  localparam int xlen = legv8_datapath_pkg::xlen;
  localparam int aw   = legv8_datapath_pkg::reg_addr_width;

  logic [aw-1:0]               rs1_addr;
  logic [aw-1:0]               rs2_addr;
  logic [xlen-1:0]             rs1_data;
  logic [xlen-1:0]             rs2_data;
  legv8_isa_pkg::instr_kind_t  kind;
  legv8_datapath_pkg::alu_op_t alu_op;
  logic [aw-1:0]               rd;
  logic [xlen-1:0]             imm;
  logic                        wb_en;  // Writeback port back into the register file
  logic [aw-1:0]               wb_addr;
  logic [xlen-1:0]             wb_data;

  fetch_decode #(
    .reset_pc(reset_pc)
  ) u_fetch_decode (
    .CLOCK   (CLOCK),
    .rst     (rst),
    .instr   (instr),
    .pc      (pc),
    .rs1_addr(rs1_addr),
    .rs2_addr(rs2_addr),
    .kind    (kind),
    .alu_op  (alu_op),
    .rd      (rd),
    .imm     (imm)
  );

  register_file u_register_file (
    .CLOCK   (CLOCK),
    .rst     (rst),
    .rs1_addr(rs1_addr),
    .rs2_addr(rs2_addr),
    .wb_en   (wb_en),
    .wb_addr (wb_addr),
    .wb_data (wb_data),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data)
  );

  execute_memory u_execute_memory (
    .CLOCK    (CLOCK),
    .rst      (rst),
    .kind     (kind),
    .alu_op   (alu_op),
    .rd       (rd),
    .imm      (imm),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .mem_rdata(mem_rdata),
    .mem_addr (mem_addr),
    .mem_wdata(mem_wdata),
    .mem_read (mem_read),
    .mem_write(mem_write),
    .wb_en    (wb_en),
    .wb_addr  (wb_addr),
    .wb_data  (wb_data)
  );

endmodule

// File: rtl/legv8_datapath_pkg.sv
package legv8_datapath_pkg;

  localparam int xlen           = 64;
  localparam int reg_addr_width = 5;
  localparam int num_regs       = 32;

  localparam logic [reg_addr_width-1:0] zero_reg = 5'd31;  // x31 reads as zero

  // ALU control codes, same encoding as the classic LEGv8 ALU
  typedef enum logic [3:0] {
    alu_and = 4'b0000,
    alu_orr = 4'b0001,
    alu_add = 4'b0010,
    alu_sub = 4'b0110
  } alu_op_t;

  localparam logic [xlen-1:0] pc_step = 64'd4;

  // Register i comes out of reset holding i, x31 holds zero
  function automatic logic [xlen-1:0] reset_value(int idx);
    logic [xlen-1:0] val;
    val = xlen'(idx);
    if (idx[reg_addr_width-1:0] == zero_reg) begin
      val = '0;
    end
    return val;
  endfunction

endpackage

// File: rtl/legv8_isa_pkg.sv
package legv8_isa_pkg;

  localparam int instr_width  = 32;
  localparam int opcode_width = 11;

  // Full 11-bit opcode field, R-type and D-type share the same position
  typedef enum logic [opcode_width-1:0] {
    op_add  = 11'b10001011000,
    op_sub  = 11'b11001011000,
    op_and  = 11'b10001010000,
    op_orr  = 11'b10101010000,
    op_ldur = 11'b11111000010,
    op_stur = 11'b11111000000
  } opcode_t;

  localparam int rd_lsb     = 0;   // Rd, also Rt for loads and stores
  localparam int rn_lsb     = 5;   // Rn, base register for D-type
  localparam int rm_lsb     = 16;  // Rm, R-type only
  localparam int dt_imm_lsb = 12;  // D-type address offset
  localparam int opcode_lsb = 21;

  localparam int dt_imm_width = 9;

  // What an operation does as it moves down the pipe
  typedef enum logic [1:0] {
    kind_bubble = 2'b00,
    kind_alu    = 2'b01,
    kind_load   = 2'b10,
    kind_store  = 2'b11
  } instr_kind_t;

endpackage

// File: rtl/register_file.sv
`timescale 1ns/100ps

module register_file (
  input  logic                                          CLOCK,
  input  logic                                          rst,
  input  logic [legv8_datapath_pkg::reg_addr_width-1:0] rs1_addr,
  input  logic [legv8_datapath_pkg::reg_addr_width-1:0] rs2_addr,
  input  logic                                          wb_en,
  input  logic [legv8_datapath_pkg::reg_addr_width-1:0] wb_addr,
  input  logic [legv8_datapath_pkg::xlen-1:0]           wb_data,
  output logic [legv8_datapath_pkg::xlen-1:0]           rs1_data,
  output logic [legv8_datapath_pkg::xlen-1:0]           rs2_data
);

  logic [legv8_datapath_pkg::xlen-1:0] regs [legv8_datapath_pkg::num_regs];

  always_ff @(posedge CLOCK) begin
    if (rst) begin
      for (int i = 0; i < legv8_datapath_pkg::num_regs; i++) begin
        regs[i] <= legv8_datapath_pkg::reset_value(i);
      end
    end else if (wb_en && (wb_addr != legv8_datapath_pkg::zero_reg)) begin
      regs[wb_addr] <= wb_data;  // Writes to x31 dropped
    end
  end

  // No internal bypass, a write lands one edge after it is presented
  assign rs1_data = (rs1_addr == legv8_datapath_pkg::zero_reg) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == legv8_datapath_pkg::zero_reg) ? '0 : regs[rs2_addr];

  a_wb_addr_known: assert property (@(posedge CLOCK) disable iff (rst)
    wb_en |-> !$isunknown(wb_addr))
    else $error("register write with unknown address");

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the LEGv8 pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log

verilator --binary --timing --assert --top-module tb_legv8 \
  -f legv8_pipeline.f -o tb_legv8_sim > build.log 2>&1 \
  && ./obj_dir/tb_legv8_sim > sim.log 2>&1 \
  || { echo "Build or simulation error, see build.log and sim.log"; }

cat sim.log 2>/dev/null
grep -q "All tests passed" sim.log 2>/dev/null \
  && { echo "Simulation PASSED"; exit 0; } \
  || { echo "Simulation FAILED"; exit 1; }

// File: verif/clock_gen.sv
`timescale 1ns/100ps

module clock_gen (
  output logic CLOCK,
  output logic rst
);

  initial begin
    CLOCK = 1'b0;
    forever #5 CLOCK = ~CLOCK;  // 10 ns period
  end

  initial begin
    rst = 1'b1;
    repeat (2) @(posedge CLOCK);
    rst <= 1'b0;  // Two reset edges
  end

endmodule

// File: include/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

localparam logic [10:0] unknown_op = 11'h2AA;  // Not in the kept set

logic [31:0] prog [$];
logic [63:0] model_regs [32];
logic [63:0] model_mem [logic [63:0]];
logic [63:0] exp_addr [$];
logic [63:0] exp_data [$];
logic [63:0] exp_pc [$];  // Address of the store instruction

function automatic logic [31:0] r_type(legv8_isa_pkg::opcode_t op, logic [4:0] rm,
                                       logic [4:0] rn, logic [4:0] rd);
  return {op, rm, 6'b000000, rn, rd};
endfunction

function automatic logic [31:0] d_type(legv8_isa_pkg::opcode_t op, logic [8:0] off,
                                       logic [4:0] rn, logic [4:0] rt);
  return {op, off, 2'b00, rn, rt};
endfunction

// Unwritten memory returns a value spread over the whole address
function automatic logic [63:0] mem_default(logic [63:0] addr);
  return (addr * 64'h9E3779B97F4A7C15) ^ 64'h0123456789ABCDEF;
endfunction

// Three bubbles after a register writer keep the hazard rule
function automatic void add_instr(logic [31:0] word, bit writes);
  prog.push_back(word);
  if (writes) begin
    repeat (3) prog.push_back(32'h0);
  end
endfunction

function automatic legv8_isa_pkg::opcode_t random_alu_op();
  legv8_isa_pkg::opcode_t op;
  case ($urandom_range(0, 3))
    0:       op = legv8_isa_pkg::op_add;
    1:       op = legv8_isa_pkg::op_sub;
    2:       op = legv8_isa_pkg::op_and;
    default: op = legv8_isa_pkg::op_orr;
  endcase
  return op;
endfunction

// Sequential execution of prog, placed at base
function automatic void ref_run(logic [63:0] base);
  logic [31:0] w;
  logic [10:0] op;
  logic [4:0]  rd;
  logic [63:0] a;
  logic [63:0] b;
  logic [63:0] addr;
  for (int i = 0; i < prog.size(); i++) begin
    w    = prog[i];
    op   = w[31:21];
    rd   = w[4:0];
    a    = model_regs[w[9:5]];
    b    = model_regs[w[20:16]];
    addr = a + {{55{w[20]}}, w[20:12]};
    case (op)
      legv8_isa_pkg::op_add: if (rd != 5'd31) model_regs[rd] = a + b;
      legv8_isa_pkg::op_sub: if (rd != 5'd31) model_regs[rd] = a - b;
      legv8_isa_pkg::op_and: if (rd != 5'd31) model_regs[rd] = a & b;
      legv8_isa_pkg::op_orr: if (rd != 5'd31) model_regs[rd] = a | b;
      legv8_isa_pkg::op_ldur: begin
        if (rd != 5'd31) begin
          model_regs[rd] = model_mem.exists(addr) ? model_mem[addr] : mem_default(addr);
        end
      end
      legv8_isa_pkg::op_stur: begin
        model_mem[addr] = model_regs[rd];
        exp_addr.push_back(addr);
        exp_data.push_back(model_regs[rd]);
        exp_pc.push_back(base + 64'(4 * i));
      end
      default: ;  // Bubble or unknown opcode
    endcase
  end
endfunction

`endif

// File: verif/tb_legv8.sv
`timescale 1ns/100ps

module tb_legv8;

  logic        CLOCK;
  logic        rst;
  logic [31:0] instr = '0;
  logic [63:0] mem_rdata = '0;
  logic [63:0] pc;
  logic [63:0] mem_addr;
  logic [63:0] mem_wdata;
  logic        mem_read;
  logic        mem_write;

  logic [31:0] imem [logic [63:0]];  // Keyed by byte address
  logic [63:0] dmem [logic [63:0]];
  int          err_count = 0;  // Compare process
  int          other_errs = 0;
  int          pass_count = 0;
  int          fail_count = 0;

  `include "tb_ref_model.svh"

  clock_gen u_clock_gen (.CLOCK(CLOCK), .rst(rst));

  legv8_core #(.reset_pc(64'd0)) DUT (
    .CLOCK(CLOCK), .rst(rst), .instr(instr), .mem_rdata(mem_rdata), .pc(pc),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_read(mem_read), .mem_write(mem_write)
  );

  function automatic logic [63:0] read_dmem(logic [63:0] addr);
    return dmem.exists(addr) ? dmem[addr] : mem_default(addr);
  endfunction

  // Instruction and data memory models
  always @(negedge CLOCK) begin
    instr <= imem.exists(pc) ? imem[pc] : 32'h0;
    if (mem_write) begin
      dmem[mem_addr] = mem_wdata;
    end
    mem_rdata <= mem_read ? read_dmem(mem_addr) : 64'h0;
  end

  always @(negedge CLOCK) begin
    if (!rst && mem_write) begin
      if (exp_addr.size() == 0) begin
        $display("Store to %h that the program does not make", mem_addr);
        err_count++;
      end else begin
        assert (mem_addr == exp_addr[0]) else begin
          $display("FAIL mem_addr: got %h, expected %h", mem_addr, exp_addr[0]);
          err_count++;
        end
        assert (mem_wdata == exp_data[0]) else begin
          $display("FAIL mem_wdata: got %h, expected %h", mem_wdata, exp_data[0]);
          err_count++;
        end
        // Pulse follows the fetch cycle by three cycles
        assert (pc == exp_pc[0] + 64'd12) else begin
          $display("FAIL pc: got %h, expected %h", pc, exp_pc[0] + 64'd12);
          err_count++;
        end
        void'(exp_addr.pop_front());
        void'(exp_data.pop_front());
        void'(exp_pc.pop_front());
      end
    end
  end

  function automatic void seed_word(logic [63:0] addr, logic [63:0] val);
    dmem[addr]      = val;
    model_mem[addr] = val;
  endfunction

  task automatic report_test(string name, int errs_before);
    if (err_count + other_errs == errs_before) begin
      $display("Test %s: passed", name);
      pass_count++;
    end else begin
      $display("Test %s: failed", name);
      fail_count++;
    end
  endtask

  task automatic check_reset();
    int          cycles;
    logic [63:0] expect_pc;
    cycles    = 0;
    expect_pc = 64'd0;
    @(negedge CLOCK);
    while (rst !== 1'b0 && cycles < 10) begin
      assert (!mem_read && !mem_write) else begin
        $display("Memory strobe high during reset");
        other_errs++;
      end
      @(negedge CLOCK);
      cycles++;
    end
    if (rst !== 1'b0) begin
      $display("Reset was never released");
      other_errs++;
    end
    for (int i = 0; i < 6; i++) begin
      assert (pc == expect_pc) else begin
        $display("FAIL pc: got %h, expected %h", pc, expect_pc);
        other_errs++;
      end
      assert (!mem_read && !mem_write) else begin
        $display("Memory strobe high with an empty pipeline");
        other_errs++;
      end
      expect_pc = expect_pc + 64'd4;
      @(negedge CLOCK);
    end
  endtask

  task automatic run_program(string name);
    logic [63:0] base;
    int          errs_before;
    int          cycles;
    errs_before = err_count + other_errs;
    @(negedge CLOCK);
    base = pc + 64'd32;  // Room ahead of the fetch point
    ref_run(base);
    for (int i = 0; i < prog.size(); i++) begin
      imem[base + 64'(4 * i)] = prog[i];
    end
    cycles = 0;
    while (exp_addr.size() != 0 && cycles < 1000) begin
      @(negedge CLOCK);
      cycles++;
    end
    if (exp_addr.size() != 0) begin
      $display("Timed out in %s with %0d stores missing", name, exp_addr.size());
      other_errs++;
      exp_addr.delete();
      exp_data.delete();
      exp_pc.delete();
    end
    cycles = 0;
    while (pc < base + 64'(4 * prog.size()) + 64'd32 && cycles < 1000) begin
      @(negedge CLOCK);  // Let the last writebacks land
      cycles++;
    end
    if (cycles >= 1000) begin
      $display("Timed out in %s waiting for the pipeline to drain", name);
      other_errs++;
    end
    prog.delete();
    report_test(name, errs_before);
  endtask

  initial begin
    int errs_before;
    void'($urandom(83426));
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = (i == 31) ? 64'd0 : 64'(i);
    end

    errs_before = err_count + other_errs;
    check_reset();
    report_test("reset", errs_before);

    for (int r = 1; r <= 12; r++) begin
      seed_word(64'(8 * r + 128), {$urandom, $urandom});
      add_instr(d_type(legv8_isa_pkg::op_ldur, 9'(8 * r + 128), 5'd31, 5'(r)), 1'b1);
    end
    for (int i = 0; i < 16; i++) begin
      logic [4:0] rd;
      rd = 5'($urandom_range(1, 12));
      add_instr(r_type(random_alu_op(), 5'($urandom_range(1, 12)),
                       5'($urandom_range(1, 12)), rd), 1'b1);
      add_instr(d_type(legv8_isa_pkg::op_stur, 9'(8 * i), 5'd31, rd), 1'b0);
    end
    run_program("alu operations");

    for (int i = 0; i < 12; i++) begin
      logic [4:0] rn;
      logic [8:0] off;
      logic [4:0] rl;
      rn  = 5'($urandom_range(1, 12));
      off = 9'($urandom_range(0, 511));
      rl  = 5'($urandom_range(13, 20));
      add_instr(d_type(legv8_isa_pkg::op_stur, off, rn, 5'($urandom_range(0, 12))), 1'b0);
      add_instr(d_type(legv8_isa_pkg::op_ldur, 9'($urandom_range(0, 511)), rn, 5'd21), 1'b1);
      add_instr(d_type(legv8_isa_pkg::op_ldur, off, rn, rl), 1'b1);
      add_instr(d_type(legv8_isa_pkg::op_stur, 9'(8 * i), 5'd31, rl), 1'b0);
      add_instr(d_type(legv8_isa_pkg::op_stur, 9'(8 * i + 256), 5'd31, 5'd21), 1'b0);
    end
    run_program("loads and stores");

    for (int i = 0; i < 10; i++) begin
      logic [4:0] rd;
      rd = 5'($urandom_range(1, 12));
      add_instr(r_type(random_alu_op(), 5'($urandom_range(1, 12)),
                       5'($urandom_range(1, 12)), 5'd31), 1'b1);
      add_instr({unknown_op, 21'($urandom)}, 1'b0);
      add_instr(r_type(legv8_isa_pkg::op_orr, 5'd31, 5'($urandom_range(1, 12)), rd), 1'b1);
      add_instr(d_type(legv8_isa_pkg::op_stur, 9'(8 * i), 5'd31, rd), 1'b0);
      add_instr(d_type(legv8_isa_pkg::op_stur, 9'(8 * i + 96), 5'd31, 5'd31), 1'b0);
    end
    run_program("zero register and unknown opcodes");

    for (int i = 0; i < 20; i++) begin
      add_instr(d_type(legv8_isa_pkg::op_stur, 9'($urandom_range(0, 511)),
                       5'($urandom_range(0, 31)), 5'($urandom_range(0, 31))), 1'b0);
    end
    run_program("store timing");

    $display("Tests passed: %0d, failed: %0d, errors: %0d",
             pass_count, fail_count, err_count + other_errs);
    if (fail_count == 0 && err_count + other_errs == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
